// File: sources.f
hdl/rename_pkg.sv
hdl/pack_lanes.sv
hdl/free_list.sv
hdl/rename_map.sv
hdl/rename_unit.sv
bench/rename_assert.sv
bench/rename_tb.sv

// File: run.sh
#!/bin/sh
# Builds the rename testbench with Verilator and runs it.
# The exit status of the simulation is the result of the regression.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module rename_tb \
  -f sources.f

./obj_dir/Vrename_tb

// File: bench/rename_tb.sv
`timescale 1ns/1ps

module rename_tb;

  localparam int CLK_PERIOD = 20;
  localparam int DRIVE_DELAY = 2;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_CYCLES = 4000;
  localparam int WATCHDOG_MARGIN = 100;
  localparam int SEED = 29354;
  localparam int PHASE_CYCLES = 150;  // Alternating drain and refill of the free list

  typedef rename_pkg::rename_req_t [rename_pkg::RENAME_WIDTH-1:0] req_group_t;
  typedef rename_pkg::rename_rsp_t [rename_pkg::RENAME_WIDTH-1:0] rsp_group_t;
  typedef rename_pkg::retire_t [rename_pkg::RENAME_WIDTH-1:0]     retire_group_t;

  logic          clk;
  logic          rst;
  req_group_t    req;
  retire_group_t retire;
  logic          ready;
  rsp_group_t    rsp;

  // Reference model
  rename_pkg::phys_reg_t model_map [rename_pkg::NUM_ARCH_REGS];
  rename_pkg::phys_reg_t free_q [$];
  rename_pkg::phys_reg_t pending_q [$];  // Old mappings not yet retired
  rsp_group_t            expect_q [$];   // One entry per cycle

  int   stall_drops;
  int   recoveries;
  logic prev_ready;

  rename_unit UUT (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .retire (retire),
    .ready  (ready),
    .rsp    (rsp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic compare_field(input string name, input int act, input int exp);
    if (act != exp) begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, act, exp);
      $display("Regression failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_rsp(input rename_pkg::rename_rsp_t act,
                           input rename_pkg::rename_rsp_t exp, input int lane);
    compare_field($sformatf("rsp[%0d].valid", lane), int'(act.valid), int'(exp.valid));
    if (exp.valid) begin
      compare_field($sformatf("rsp[%0d].dst_valid", lane), int'(act.dst_valid),
                    int'(exp.dst_valid));
      compare_field($sformatf("rsp[%0d].psrc1", lane), int'(act.psrc1), int'(exp.psrc1));
      compare_field($sformatf("rsp[%0d].psrc2", lane), int'(act.psrc2), int'(exp.psrc2));
      if (exp.dst_valid) begin  // pdst and old_pdst only mean something with a dst
        compare_field($sformatf("rsp[%0d].pdst", lane), int'(act.pdst), int'(exp.pdst));
        compare_field($sformatf("rsp[%0d].old_pdst", lane), int'(act.old_pdst),
                      int'(exp.old_pdst));
      end
    end
  endtask

  task automatic check_ready(input logic act, input logic exp);
    compare_field("ready", int'(act), int'(exp));
  endtask

  task automatic check_group();
    rsp_group_t e;
    if (expect_q.size() == 0) begin
      $display("No expected response left in the model queue");
      $display("Regression failed");
      $fatal(1, "model queue empty");
    end else begin
      e = expect_q.pop_front();
      for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
        check_rsp(rsp[i], e[i], i);
      end
    end
  endtask

  function automatic rename_pkg::rename_req_t make_req(input logic valid, input logic dst_valid,
                                                      input int dst, input int src1,
                                                      input int src2);
    rename_pkg::rename_req_t r;
    r.valid     = valid;
    r.dst_valid = dst_valid;
    r.dst       = rename_pkg::arch_reg_t'(dst);
    r.src1      = rename_pkg::arch_reg_t'(src1);
    r.src2      = rename_pkg::arch_reg_t'(src2);
    return r;
  endfunction

  function automatic int pick_reg(input logic narrow);
    if (narrow) begin
      return int'($urandom_range(0, 3));  // Few registers, many collisions
    end
    return int'($urandom_range(0, rename_pkg::NUM_ARCH_REGS - 1));
  endfunction

  // Identity map, no-dst lane, then lane 1 hitting lane 0's dst
  function automatic req_group_t directed_group(input int n);
    req_group_t g;
    g = '0;
    case (n)
      0: begin
        g[0] = make_req(1'b1, 1'b1, 3, 1, 2);
        g[1] = make_req(1'b1, 1'b1, 4, 6, 7);
      end
      1: begin
        g[0] = make_req(1'b1, 1'b0, 10, 3, 4);
        g[1] = make_req(1'b1, 1'b1, 3, 3, 10);
      end
      default: begin
        g[0] = make_req(1'b1, 1'b1, 5, 5, 4);
        g[1] = make_req(1'b1, 1'b1, 5, 5, 3);
      end
    endcase
    return g;
  endfunction

  function automatic req_group_t random_group();
    req_group_t g;
    logic       narrow;
    narrow = ($urandom_range(0, 3) == 0);
    for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
      g[i] = make_req($urandom_range(0, 9) < 8, $urandom_range(0, 3) != 0,
                      pick_reg(narrow), pick_reg(narrow), pick_reg(narrow));
    end
    case ($urandom_range(0, 5))  // Force a same-group dependency now and then
      0: g[1].src1 = g[0].dst;
      1: g[1].src2 = g[0].dst;
      2: g[1].dst = g[0].dst;
      default: ;
    endcase
    return g;
  endfunction

  task automatic drive_retires(input int cycle);
    int n;
    int lane;
    if ((cycle / PHASE_CYCLES) % 2 == 0) begin
      n = ($urandom_range(0, 7) == 0) ? 1 : 0;
    end else begin
      n = ($urandom_range(0, 3) == 0) ? int'($urandom_range(0, 1)) : 2;
    end
    if (n > pending_q.size()) n = pending_q.size();
    for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
      retire[i].free_valid = 1'b0;
      retire[i].preg = rename_pkg::phys_reg_t'($urandom_range(0, 63));  // Ignored garbage
    end
    if (n == 2) begin
      for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
        retire[i].free_valid = 1'b1;
        retire[i].preg = pending_q.pop_front();
      end
    end else if (n == 1) begin
      lane = int'($urandom_range(0, 1));
      retire[lane].free_valid = 1'b1;
      retire[lane].preg = pending_q.pop_front();
    end
  endtask

  // Lanes in order, so lane 1 already sees lane 0's new mapping
  task automatic accept_group(input req_group_t g, input logic grant);
    rsp_group_t e;
    e = '0;
    for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
      if (grant && g[i].valid) begin
        e[i].valid = 1'b1;
        e[i].dst_valid = g[i].dst_valid;
        e[i].psrc1 = model_map[g[i].src1];
        e[i].psrc2 = model_map[g[i].src2];
        if (g[i].dst_valid) begin
          e[i].old_pdst = model_map[g[i].dst];
          e[i].pdst = free_q.pop_front();
          model_map[g[i].dst] = e[i].pdst;
          pending_q.push_back(e[i].old_pdst);
        end
      end
    end
    expect_q.push_back(e);
  endtask

  task automatic apply_frees();
    for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
      if (retire[i].free_valid) free_q.push_back(retire[i].preg);
    end
  endtask

  task automatic reset_model();
    rsp_group_t idle;
    idle = '0;
    for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i++) begin
      model_map[i] = rename_pkg::phys_reg_t'(i);
    end
    for (int i = rename_pkg::NUM_ARCH_REGS; i < rename_pkg::NUM_PHYS_REGS; i++) begin
      free_q.push_back(rename_pkg::phys_reg_t'(i));
    end
    expect_q.push_back(idle);  // rsp right after reset
  endtask

  initial begin
    #((RESET_CYCLES + NUM_CYCLES + WATCHDOG_MARGIN) * CLK_PERIOD);
    $display("Watchdog expired before the test finished");
    $display("Regression failed");
    $fatal(1, "timeout");
  end

  initial begin
    req_group_t g;
    logic       exp_ready;
    logic       any_valid;
    void'($urandom(SEED));
    clk = 1'b0;
    rst = 1'b1;
    req = '0;
    retire = '0;
    stall_drops = 0;
    recoveries = 0;
    prev_ready = 1'b1;
    reset_model();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
      check_group();
      exp_ready = (free_q.size() >= rename_pkg::RENAME_WIDTH);
      check_ready(ready, exp_ready);
      g = (cycle < 3) ? directed_group(cycle) : random_group();
      req = g;  // Driven whether or not ready is high
      drive_retires(cycle);
      any_valid = 1'b0;
      for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
        any_valid = any_valid | g[i].valid;
      end
      if (!exp_ready && any_valid) stall_drops++;
      if (exp_ready && !prev_ready) recoveries++;
      prev_ready = exp_ready;
      accept_group(g, exp_ready);
      apply_frees();  // Frees only count from the next cycle
      @(posedge clk);
      #DRIVE_DELAY;
    end

    req = '0;
    retire = '0;
    check_group();
    if (stall_drops == 0 || recoveries == 0) begin
      $display("Back-pressure not exercised: %0d dropped groups, %0d recoveries",
               stall_drops, recoveries);
      $display("Regression failed");
      $fatal(1, "no back-pressure seen");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

// File: bench/rename_assert.sv
`timescale 1ns/1ps

// Free list occupancy checks bound into every free_list instance
module free_list_assert (
  input logic                    clk,
  input logic                    rst,
  input logic                    ready,
  input rename_pkg::phys_reg_t   head,
  input rename_pkg::phys_reg_t   tail,
  input rename_pkg::free_count_t count,
  input rename_pkg::free_count_t num_alloc
);

  rename_pkg::phys_reg_t ptr_gap;  // Entries between head and tail, modulo the queue size

  assign ptr_gap = tail - head;

  // Queue can never hold more than every physical register
  count_in_range: assert property (@(posedge clk) disable iff (rst)
    count <= rename_pkg::free_count_t'(rename_pkg::NUM_PHYS_REGS))
    else $error("free count above the number of physical registers");

  // Grant only when a whole group sits between head and tail
  // A full queue also has tail equal to head
  ready_matches_queue: assert property (@(posedge clk) disable iff (rst)
    count != rename_pkg::free_count_t'(rename_pkg::NUM_PHYS_REGS) |->
      ready == (ptr_gap >= rename_pkg::phys_reg_t'(rename_pkg::RENAME_WIDTH)))
    else $error("ready disagrees with the entries between head and tail");

  // Allocation larger than the count would wrap below zero at the edge
  no_underflow: assert property (@(posedge clk) disable iff (rst)
    num_alloc <= count)
    else $error("allocation exceeds the free count");

endmodule

bind free_list free_list_assert u_free_list_assert (
  .clk       (clk),
  .rst       (rst),
  .ready     (ready),
  .head      (head),
  .tail      (tail),
  .count     (count),
  .num_alloc (num_alloc)
);

// File: hdl/rename_unit.sv
`timescale 1ns/1ps

module rename_unit (
  input  logic                                                    clk,
  input  logic                                                    rst,
  input  rename_pkg::rename_req_t [rename_pkg::RENAME_WIDTH-1:0]  req,
  input  rename_pkg::retire_t [rename_pkg::RENAME_WIDTH-1:0]      retire,
  output logic                                                    ready,
  output rename_pkg::rename_rsp_t [rename_pkg::RENAME_WIDTH-1:0]  rsp
);

  logic [rename_pkg::RENAME_WIDTH-1:0]                  accept;
  logic [rename_pkg::RENAME_WIDTH-1:0]                  alloc_mask;
  rename_pkg::phys_reg_t [rename_pkg::RENAME_WIDTH-1:0] alloc_pregs;

  // A group goes in whole or not at all
  always_comb begin
    for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
      accept[i]     = req[i].valid & ready;
      alloc_mask[i] = accept[i] & req[i].dst_valid;  // Only dst lanes pop the queue
    end
  end

  free_list u_free_list (
    .clk         (clk),
    .rst         (rst),
    .alloc_mask  (alloc_mask),
    .ready       (ready),
    .alloc_pregs (alloc_pregs),
    .retire      (retire)
  );

  rename_map u_rename_map (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .accept      (accept),
    .alloc_pregs (alloc_pregs),
    .rsp         (rsp)
  );

endmodule

// File: hdl/rename_map.sv
`timescale 1ns/1ps

module rename_map (
  input  logic                                                    clk,
  input  logic                                                    rst,
  input  rename_pkg::rename_req_t [rename_pkg::RENAME_WIDTH-1:0]  req,
  input  logic [rename_pkg::RENAME_WIDTH-1:0]                     accept,
  input  rename_pkg::phys_reg_t [rename_pkg::RENAME_WIDTH-1:0]    alloc_pregs,
  output rename_pkg::rename_rsp_t [rename_pkg::RENAME_WIDTH-1:0]  rsp
);

  // Architectural to physical mapping
  rename_pkg::phys_reg_t map_table [rename_pkg::NUM_ARCH_REGS];

  logic [rename_pkg::RENAME_WIDTH-1:0]                    dst_mask;   // Accepted lanes with a dst
  rename_pkg::phys_reg_t [rename_pkg::RENAME_WIDTH-1:0]   lane_ids;
  logic [rename_pkg::RENAME_WIDTH-1:0]                    rank_mask;
  rename_pkg::phys_reg_t [rename_pkg::RENAME_WIDTH-1:0]   rank_lane;  // Lane holding each rank
  rename_pkg::phys_reg_t [rename_pkg::RENAME_WIDTH-1:0]   pdst;
  rename_pkg::rename_rsp_t [rename_pkg::RENAME_WIDTH-1:0] rsp_next;

  always_comb begin
    for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
      dst_mask[i] = accept[i] & req[i].dst_valid;
      lane_ids[i] = rename_pkg::phys_reg_t'(i);  // Lane number carried as payload
    end
  end

  // Slot k of the packed output is the k-th destination lane
  pack_lanes u_pack_dst (
    .mask_in  (dst_mask),
    .preg_in  (lane_ids),
    .mask_out (rank_mask),
    .preg_out (rank_lane)
  );

  // Scatter head entries back to the lanes that asked
  always_comb begin
    pdst = '0;
    for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
      for (int k = 0; k < rename_pkg::RENAME_WIDTH; k++) begin
        if (rank_mask[k] && rank_lane[k] == rename_pkg::phys_reg_t'(i)) begin
          pdst[i] = alloc_pregs[k];
        end
      end
    end
  end

  // Table read, then override with older lanes of the same group
  always_comb begin
    for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
      rsp_next[i].valid     = accept[i];
      rsp_next[i].dst_valid = req[i].dst_valid;
      rsp_next[i].psrc1     = map_table[req[i].src1];
      rsp_next[i].psrc2     = map_table[req[i].src2];
      rsp_next[i].old_pdst  = map_table[req[i].dst];
      rsp_next[i].pdst      = pdst[i];

      // Later older lanes win, so the nearest writer sticks
      for (int j = 0; j < i; j++) begin
        if (dst_mask[j]) begin
          if (req[j].dst == req[i].src1) begin
            rsp_next[i].psrc1 = pdst[j];
          end
          if (req[j].dst == req[i].src2) begin
            rsp_next[i].psrc2 = pdst[j];
          end
          if (req[j].dst == req[i].dst) begin
            rsp_next[i].old_pdst = pdst[j];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      // Identity map
      for (int i = 0; i < rename_pkg::NUM_ARCH_REGS; i++) begin
        map_table[i] <= rename_pkg::phys_reg_t'(i);
      end
    end else begin
      for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
        if (dst_mask[i]) begin
          map_table[req[i].dst] <= pdst[i];  // Highest lane lands last
        end
      end
    end
  end

  // Response stage, only valid needs clearing
  always_ff @(posedge clk) begin
    rsp <= rsp_next;
    if (rst) begin
      for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
        rsp[i].valid <= 1'b0;
      end
    end
  end

endmodule

// File: hdl/free_list.sv
`timescale 1ns/1ps

module free_list (
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  logic [rename_pkg::RENAME_WIDTH-1:0]                   alloc_mask,
  output logic                                                  ready,
  output rename_pkg::phys_reg_t [rename_pkg::RENAME_WIDTH-1:0]  alloc_pregs,
  input  rename_pkg::retire_t [rename_pkg::RENAME_WIDTH-1:0]    retire
);

  // Circular queue of free physical registers
  rename_pkg::phys_reg_t   queue [rename_pkg::NUM_PHYS_REGS];
  rename_pkg::phys_reg_t   head;   // Next register to hand out
  rename_pkg::phys_reg_t   tail;   // Next slot for a freed register
  rename_pkg::free_count_t count;  // Free entries between head and tail

  logic [rename_pkg::RENAME_WIDTH-1:0]                  retire_mask;
  rename_pkg::phys_reg_t [rename_pkg::RENAME_WIDTH-1:0] retire_pregs;
  logic [rename_pkg::RENAME_WIDTH-1:0]                  free_mask;
  rename_pkg::phys_reg_t [rename_pkg::RENAME_WIDTH-1:0] free_pregs;

  rename_pkg::free_count_t num_alloc;
  rename_pkg::free_count_t num_free;
  rename_pkg::phys_reg_t   head_next;
  rename_pkg::phys_reg_t   tail_next;
  rename_pkg::free_count_t count_next;

  // Split the retire structs for the packer
  always_comb begin
    for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
      retire_mask[i]  = retire[i].free_valid;
      retire_pregs[i] = retire[i].preg;
    end
  end

  pack_lanes u_pack_frees (
    .mask_in  (retire_mask),
    .preg_in  (retire_pregs),
    .mask_out (free_mask),
    .preg_out (free_pregs)
  );

  // Whole group or nothing, frees of this cycle not counted
  assign ready = count >= rename_pkg::free_count_t'(rename_pkg::RENAME_WIDTH);

  // Head entries offered in lane order
  always_comb begin
    for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
      alloc_pregs[i] = queue[head + rename_pkg::phys_reg_t'(i)];  // Wraps at 64
    end
  end

  always_comb begin
    num_alloc = rename_pkg::free_count_t'($countones(alloc_mask));
    num_free  = rename_pkg::free_count_t'($countones(free_mask));

    head_next  = head + rename_pkg::phys_reg_t'(num_alloc);
    tail_next  = tail + rename_pkg::phys_reg_t'(num_free);
    count_next = count + num_free - num_alloc;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      // Registers 32..63 start free, arch regs own 0..31
      for (int i = 0; i < rename_pkg::NUM_PHYS_REGS; i++) begin
        queue[i] <= rename_pkg::phys_reg_t'(i + rename_pkg::NUM_ARCH_REGS);
      end
      head  <= '0;
      tail  <= rename_pkg::phys_reg_t'(rename_pkg::NUM_FREE_AT_RESET);
      count <= rename_pkg::free_count_t'(rename_pkg::NUM_FREE_AT_RESET);
    end else begin
      // Compacted frees land at consecutive tail slots
      for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
        if (free_mask[i]) begin
          queue[tail + rename_pkg::phys_reg_t'(i)] <= free_pregs[i];
        end
      end
      head  <= head_next;
      tail  <= tail_next;
      count <= count_next;
    end
  end

endmodule

// File: hdl/pack_lanes.sv
`timescale 1ns/1ps

// Squeezes the set lanes toward slot 0, order kept
module pack_lanes (
  input  logic [rename_pkg::RENAME_WIDTH-1:0]                        mask_in,
  input  rename_pkg::phys_reg_t [rename_pkg::RENAME_WIDTH-1:0]       preg_in,
  output logic [rename_pkg::RENAME_WIDTH-1:0]                        mask_out,
  output rename_pkg::phys_reg_t [rename_pkg::RENAME_WIDTH-1:0]       preg_out
);

  always_comb begin
    int unsigned slot;

    slot     = 0;
    mask_out = '0;  // Unused slots stay clear
    preg_out = '0;

    for (int i = 0; i < rename_pkg::RENAME_WIDTH; i++) begin
      if (mask_in[i]) begin
        mask_out[slot] = 1'b1;
        preg_out[slot] = preg_in[i];
        slot++;
      end
    end
  end

endmodule

// File: hdl/rename_pkg.sv
package rename_pkg;

  // Group and register file sizes
  localparam int RENAME_WIDTH = 2;  // Lanes per rename or retire group
  localparam int NUM_ARCH_REGS = 32;
  localparam int NUM_PHYS_REGS = 64;
  localparam int NUM_FREE_AT_RESET = NUM_PHYS_REGS - NUM_ARCH_REGS;

  localparam int ARCH_REG_BITS = $clog2(NUM_ARCH_REGS);
  localparam int PHYS_REG_BITS = $clog2(NUM_PHYS_REGS);

  typedef logic [ARCH_REG_BITS-1:0] arch_reg_t;
  typedef logic [PHYS_REG_BITS-1:0] phys_reg_t;
  typedef logic [PHYS_REG_BITS:0] free_count_t;  // Needs to hold NUM_PHYS_REGS itself

  // One decoded instruction entering rename
  typedef struct packed {
    logic      valid;
    logic      dst_valid;
    arch_reg_t dst;
    arch_reg_t src1;
    arch_reg_t src2;
  } rename_req_t;

  // Renamed operands, one cycle after acceptance
  typedef struct packed {
    logic      valid;
    logic      dst_valid;
    phys_reg_t psrc1;
    phys_reg_t psrc2;
    phys_reg_t pdst;
    phys_reg_t old_pdst;  // Previous mapping of dst, freed at retire
  } rename_rsp_t;

  // Register handed back by retirement
  typedef struct packed {
    logic      free_valid;
    phys_reg_t preg;
  } retire_t;

endpackage
